/* design/fb_scanout.sv */
// ==========================================================================
// raster scan of the framebuffer through the CLUT to 12-bit RGB
// outputs trail the raster counters by 3 clocks, no sync pulses generated
// ==========================================================================
`timescale 1ns/1ps

module fb_scanout (
    input  logic              clk_sys,
    input  logic              rst_sys,
    output gfx_pkg::fb_addr_t fb_raddr,
    input  gfx_pkg::cidx_t    fb_rdata,
    output gfx_pkg::cidx_t    clut_raddr,
    input  gfx_pkg::colr_t    clut_rdata,
    output gfx_pkg::colr_t    rgb,
    output logic              de,
    output logic              frame
);

    import gfx_pkg::*;

    localparam int hw = $clog2(h_total);
    localparam int vw = $clog2(v_total);

    logic [hw-1:0] sx;         // raster column
    logic [vw-1:0] sy;         // raster line
    logic          active;     // pixel inside framebuffer area
    logic          first;      // top left pixel
    logic [1:0]    active_sr;  // [0] lines up with fb_rdata, [1] with clut_rdata
    logic [1:0]    frame_sr;

    // free running raster counters
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == hw'(h_total - 1)) begin
            sx <= '0;
            if (sy == vw'(v_total - 1)) begin
                sy <= '0;  // wrap to next frame
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    assign active = (sx < fb_w) && (sy < fb_h);
    assign first  = (sx == '0) && (sy == '0);

    // framebuffer read, address parked at zero in blanking
    assign fb_raddr = active ? fb_addr_t'(sy * fb_w + sx) : '0;

    // index returned by the framebuffer addresses the CLUT directly
    assign clut_raddr = fb_rdata;

    // flag pipeline matching the two RAM reads
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            active_sr <= '0;
            frame_sr  <= '0;
        end else begin
            active_sr <= {active_sr[0], active};
            frame_sr  <= {frame_sr[0], first};
        end
    end

    // output register, black outside the active area
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            rgb   <= '0;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            rgb   <= active_sr[1] ? clut_rdata : '0;
            de    <= active_sr[1];
            frame <= frame_sr[1];  // with first active pixel
        end
    end

endmodule

/* design/gfx_apb_regs.sv */
// ==========================================================================
// APB slave for line setup, start, busy status and CLUT writes
// pready tied high, start while busy is dropped and flagged by pslverr
// ==========================================================================
`timescale 1ns/1ps

module gfx_apb_regs (
    input  logic                             clk_sys,
    input  logic                             rst_sys,
    // APB
    input  logic [gfx_pkg::apb_addrw-1:0]    paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    // drawer
    output logic                             start,
    output gfx_pkg::coord_t                  x0,
    output gfx_pkg::coord_t                  y0,
    output gfx_pkg::coord_t                  x1,
    output gfx_pkg::coord_t                  y1,
    output gfx_pkg::cidx_t                   cidx,
    input  logic                             busy,
    // CLUT write port
    output logic                             clut_we,
    output gfx_pkg::cidx_t                   clut_waddr,
    output gfx_pkg::colr_t                   clut_wdata
);

    import gfx_pkg::*;

    localparam int clut_top = int'(reg_clut_base) + 4 * clut_len;  // first address past window

    logic                 access;    // APB access phase
    logic                 wr;
    logic                 rd;
    logic                 reg_sel;   // one of the plain registers
    logic                 clut_sel;  // aligned word inside CLUT window
    logic                 start_req;
    logic [apb_addrw-1:0] clut_off;

    assign access = psel && penable;
    assign wr     = access && pwrite;
    assign rd     = access && !pwrite;

    always_comb begin
        case (paddr)
            reg_ctrl, reg_status, reg_x0, reg_y0,
            reg_x1, reg_y1, reg_cidx: reg_sel = 1'b1;
            default:                  reg_sel = 1'b0;
        endcase
    end

    assign clut_sel = (paddr >= reg_clut_base) && (int'(paddr) < clut_top)
                    && (paddr[1:0] == 2'b00);

    // start request, only becomes a pulse when the drawer is idle
    assign start_req = wr && (paddr == reg_ctrl) && pwdata[0];
    assign start     = start_req && !busy;

    // CLUT writes go straight through on the access phase
    assign clut_off   = paddr - reg_clut_base;
    assign clut_we    = wr && clut_sel;
    assign clut_waddr = clut_off[cidxw+1:2];  // word index
    assign clut_wdata = pwdata[colrw-1:0];

    assign pready  = 1'b1;  // no wait states
    // unmapped, CLUT read, or start refused
    assign pslverr = access && (!(reg_sel || clut_sel) || (rd && clut_sel)
                              || (start_req && busy));

    // line registers, free to change while drawing
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            x0   <= '0;
            y0   <= '0;
            x1   <= '0;
            y1   <= '0;
            cidx <= '0;
        end else if (wr) begin
            case (paddr)
                reg_x0:   x0   <= coord_t'(pwdata[cordw-1:0]);
                reg_y0:   y0   <= coord_t'(pwdata[cordw-1:0]);
                reg_x1:   x1   <= coord_t'(pwdata[cordw-1:0]);
                reg_y1:   y1   <= coord_t'(pwdata[cordw-1:0]);
                reg_cidx: cidx <= pwdata[cidxw-1:0];
                default: ;  // ctrl and status hold nothing
            endcase
        end
    end

    // read mux, coordinates come back sign extended
    always_comb begin
        case (paddr)
            reg_status: prdata = {31'b0, busy};
            reg_x0:     prdata = {{(32-cordw){x0[cordw-1]}}, x0};
            reg_y0:     prdata = {{(32-cordw){y0[cordw-1]}}, y0};
            reg_x1:     prdata = {{(32-cordw){x1[cordw-1]}}, x1};
            reg_y1:     prdata = {{(32-cordw){y1[cordw-1]}}, y1};
            reg_cidx:   prdata = {{(32-cidxw){1'b0}}, cidx};
            default:    prdata = '0;  // ctrl reads zero
        endcase
    end

endmodule

/* design/gfx_pkg.sv */
// ==========================================================================
// shared sizes, types and APB register map for the raster graphics block
// framebuffer is fixed at 32x24 with 4-bit indices, CLUT holds 12-bit RGB
// ==========================================================================

package gfx_pkg;

    // framebuffer geometry
    localparam int fb_w      = 32;
    localparam int fb_h      = 24;
    localparam int fb_pixels = fb_w * fb_h;  // 768 words
    localparam int fb_addrw  = 10;

    typedef logic [fb_addrw-1:0] fb_addr_t;

    // colour index and palette
    localparam int cidxw    = 4;
    localparam int clut_len = 16;
    localparam int colrw    = 12;  // r, g, b nibbles, red on top

    typedef logic [cidxw-1:0] cidx_t;
    typedef logic [colrw-1:0] colr_t;

    // signed so that off-screen endpoints can be expressed
    localparam int cordw = 8;

    typedef logic signed [cordw-1:0] coord_t;

    // raster, active area sits at the start of each line and frame
    localparam int h_total = 40;
    localparam int v_total = 28;

    // APB byte addresses
    localparam int apb_addrw = 8;

    localparam logic [apb_addrw-1:0] reg_ctrl      = 8'h00;  // bit 0 start
    localparam logic [apb_addrw-1:0] reg_status    = 8'h04;  // bit 0 busy
    localparam logic [apb_addrw-1:0] reg_x0        = 8'h08;
    localparam logic [apb_addrw-1:0] reg_y0        = 8'h0C;
    localparam logic [apb_addrw-1:0] reg_x1        = 8'h10;
    localparam logic [apb_addrw-1:0] reg_y1        = 8'h14;
    localparam logic [apb_addrw-1:0] reg_cidx      = 8'h18;
    localparam logic [apb_addrw-1:0] reg_clut_base = 8'h40;  // 16 words, write only

endpackage

/* design/gfx_top.sv */
// ==========================================================================
// raster graphics top, APB line drawer into a 32x24 framebuffer
// single clock, scanout runs continuously from reset
// ==========================================================================
`timescale 1ns/1ps

module gfx_top (
    input  logic                          clk_sys,
    input  logic                          rst_sys,
    // APB slave
    input  logic [gfx_pkg::apb_addrw-1:0] paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    // video
    output gfx_pkg::colr_t                rgb,
    output logic                          de,
    output logic                          frame
);

    import gfx_pkg::*;

    // register block to drawer
    logic     start;
    coord_t   x0;
    coord_t   y0;
    coord_t   x1;
    coord_t   y1;
    cidx_t    cidx;
    logic     busy;

    // CLUT write side
    logic     clut_we;
    cidx_t    clut_waddr;
    colr_t    clut_wdata;

    // framebuffer ports
    logic     fb_we;
    fb_addr_t fb_waddr;
    cidx_t    fb_wdata;
    fb_addr_t fb_raddr;
    cidx_t    fb_rdata;

    // CLUT read side
    cidx_t    clut_raddr;
    colr_t    clut_rdata;

    gfx_apb_regs u_regs (
        .clk_sys, .rst_sys,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .start, .x0, .y0, .x1, .y1, .cidx, .busy,
        .clut_we, .clut_waddr, .clut_wdata
    );

    line_draw u_draw (
        .clk_sys, .rst_sys,
        .start, .x0, .y0, .x1, .y1, .cidx,
        .busy, .fb_we, .fb_waddr, .fb_wdata
    );

    // framebuffer of colour indices
    sdp_ram #(.word_t(cidx_t), .depth(fb_pixels)) u_fb (
        .clk_sys,
        .we(fb_we), .waddr(fb_waddr), .raddr(fb_raddr),
        .wdata(fb_wdata), .rdata(fb_rdata)
    );

    // palette, written from APB
    sdp_ram #(.word_t(colr_t), .depth(clut_len)) u_clut (
        .clk_sys,
        .we(clut_we), .waddr(clut_waddr), .raddr(clut_raddr),
        .wdata(clut_wdata), .rdata(clut_rdata)
    );

    fb_scanout u_scan (
        .clk_sys, .rst_sys,
        .fb_raddr, .fb_rdata,
        .clut_raddr, .clut_rdata,
        .rgb, .de, .frame
    );

endmodule

/* design/line_draw.sv */
// ==========================================================================
// Bresenham line walker, one pixel per clock in all octants
// inputs latched at start, pixels outside the 32x24 buffer are not written
// ==========================================================================
`timescale 1ns/1ps

module line_draw (
    input  logic              clk_sys,
    input  logic              rst_sys,
    input  logic              start,
    input  gfx_pkg::coord_t   x0,
    input  gfx_pkg::coord_t   y0,
    input  gfx_pkg::coord_t   x1,
    input  gfx_pkg::coord_t   y1,
    input  gfx_pkg::cidx_t    cidx,
    output logic              busy,
    output logic              fb_we,
    output gfx_pkg::fb_addr_t fb_waddr,
    output gfx_pkg::cidx_t    fb_wdata
);

    import gfx_pkg::*;

    // error term needs room for 2*(dx+dy) on a 9-bit delta
    localparam int ew = cordw + 4;

    logic signed [ew-1:0] adx;      // |x1-x0| at setup
    logic signed [ew-1:0] ady;      // |y1-y0| at setup
    logic signed [ew-1:0] dx;       // positive
    logic signed [ew-1:0] dy;       // negative, as in the usual formulation
    logic signed [ew-1:0] err;
    logic signed [ew-1:0] err_nxt;
    logic signed [ew-1:0] e2;
    logic                 x_neg;    // step direction
    logic                 y_neg;
    coord_t               x;
    coord_t               y;
    coord_t               x_nxt;
    coord_t               y_nxt;
    coord_t               xe;       // end point
    coord_t               ye;
    logic                 last;
    logic                 in_range;

    // setup deltas straight from the inputs so stepping starts next cycle
    always_comb begin
        logic signed [ew-1:0] ddx;
        logic signed [ew-1:0] ddy;
        ddx = ew'(x1) - ew'(x0);
        ddy = ew'(y1) - ew'(y0);
        adx = (ddx < 0) ? -ddx : ddx;
        ady = (ddy < 0) ? -ddy : ddy;
    end

    // one Bresenham step
    always_comb begin
        e2      = err + err;
        err_nxt = err;
        x_nxt   = x;
        y_nxt   = y;
        if (e2 >= dy) begin
            err_nxt = err_nxt + dy;
            x_nxt   = x_neg ? x - coord_t'(1) : x + coord_t'(1);
        end
        if (e2 <= dx) begin
            err_nxt = err_nxt + dx;
            y_nxt   = y_neg ? y - coord_t'(1) : y + coord_t'(1);
        end
    end

    assign last = (x == xe) && (y == ye);

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            busy <= 1'b0;
        end else if (start && !busy) begin
            busy <= 1'b1;
        end else if (busy && last) begin
            busy <= 1'b0;  // drops the cycle after the end pixel
        end
    end

    // walk state, latched at start and stepped while busy
    always_ff @(posedge clk_sys) begin
        if (start && !busy) begin
            x        <= x0;
            y        <= y0;
            xe       <= x1;
            ye       <= y1;
            fb_wdata <= cidx;
            dx       <= adx;
            dy       <= -ady;
            err      <= adx - ady;
            x_neg    <= (x1 < x0);
            y_neg    <= (y1 < y0);
        end else if (busy && !last) begin
            x   <= x_nxt;
            y   <= y_nxt;
            err <= err_nxt;
        end
    end

    // clip against the buffer
    assign in_range = (x >= 0) && (x < fb_w) && (y >= 0) && (y < fb_h);
    assign fb_we    = busy && in_range;
    assign fb_waddr = fb_addr_t'(y * fb_w + x);  // valid only when in range

endmodule

/* design/sdp_ram.sv */
// ==========================================================================
// simple dual-port RAM, one write port and one registered read port
// read during write to the same address returns the old word
// ==========================================================================
`timescale 1ns/1ps

module sdp_ram #(
    parameter type word_t = logic [7:0],
    parameter int  depth  = 16
) (
    input  logic                     clk_sys,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  logic [$clog2(depth)-1:0] raddr,
    input  word_t                    wdata,
    output word_t                    rdata
);

    word_t mem [depth];

    // power-up contents all zero
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // one cycle latency
    end

endmodule

/* list.f */
+incdir+testbench
design/gfx_pkg.sv
design/sdp_ram.sv
design/gfx_apb_regs.sv
design/line_draw.sv
design/fb_scanout.sv
design/gfx_top.sv
testbench/tb_gfx_top.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it, exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_gfx_top -f list.f -o tb_gfx_top \
    && ./obj_dir/tb_gfx_top \
    || exit 1

/* testbench/tb_gfx_model.svh */
// ==========================================================================
// testbench helpers, APB master, LFSR and a reference Bresenham model
// shares clock, bus signals and the shadow array with tb_gfx_top
// ==========================================================================
`ifndef TB_GFX_MODEL_SVH
`define TB_GFX_MODEL_SVH

task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
        $display("ERROR %s: got 0x%h expected 0x%h", name, act, exp);
        $display("Done: errors found");
        $fatal(1, "value mismatch");
    end
endtask

// setup phase, access phase, sampled in the middle of the access cycle
task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
    @(posedge clk_sys);
    psel    <= 1'b1;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_sys);
    penable <= 1'b1;
    @(negedge clk_sys);
    check_value("pready", 32'(pready), 32'h1);  // never any wait state
    rdata = prdata;
    err   = pslverr;
    @(posedge clk_sys);
    psel    <= 1'b0;  // back to idle
    penable <= 1'b0;
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, wdata, rdata, err);
    check_value("pslverr", 32'(err), 32'(exp_err));
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
    apb_xfer(1'b0, addr, 32'h0, rdata, err);
endtask

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
endfunction

// walks (x0,y0) to (x1,y1), later lines overwrite, n is the pixel count
task automatic draw_ref(input int x0, input int y0, input int x1, input int y1,
                        input int c, output int n);
    int dx;
    int dy;
    int err;
    int e2;
    int x;
    int y;
    bit done;
    dx   = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy   = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative
    err  = dx + dy;
    x    = x0;
    y    = y0;
    n    = 0;
    done = 1'b0;
    while (!done) begin
        if (x >= 0 && x < fb_w && y >= 0 && y < fb_h) begin
            shadow[y * fb_w + x] = c;  // clipped otherwise
        end
        n++;
        done = (x == x1) && (y == y1);
        e2   = 2 * err;
        if (e2 >= dy) begin
            err = err + dy;
            x   = (x1 < x0) ? x - 1 : x + 1;
        end
        if (e2 <= dx) begin
            err = err + dx;
            y   = (y1 < y0) ? y - 1 : y + 1;
        end
    end
endtask

`endif

/* testbench/tb_gfx_top.sv */
// ==========================================================================
// testbench for gfx_top, draws a table of lines and checks one whole frame
// retry while busy is only tried on lines long enough to still be drawing
// ==========================================================================
`timescale 1ns/1ps

module tb_gfx_top;
    import gfx_pkg::*;

    localparam int n_lines   = 9;
    localparam int frame_len = h_total * v_total;  // 1120 clocks
    localparam int limit     = n_lines * 200 + 4 * frame_len + 100;

    logic                 clk_sys;
    logic                 rst_sys;
    logic [apb_addrw-1:0] paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    colr_t                rgb;
    logic                 de;
    logic                 frame;

    // x0, y0, x1, y1, colour index
    int line_tbl [n_lines][5] = '{
        '{ 2,   3, 29,  3, 1},  // horizontal
        '{ 5,   0,  5, 23, 2},  // vertical, full height
        '{10,   2, 16, 21, 3},  // steep
        '{30,   4,  3, 20, 4},  // negative slope
        '{20,  23, 24,  1, 9},  // steep, going up
        '{15,  12, 15, 12, 5},  // single point
        '{-6,  18, 12, 30, 6},  // off left and bottom
        '{25,  -4, 40,  8, 7},  // off top and right
        '{40, -10, 60, -2, 8}   // nothing on screen
    };
    string       reg_names [5] = '{"x0", "y0", "x1", "y1", "cidx"};
    int          shadow [fb_pixels];  // expected index per pixel, starts at 0
    colr_t       clut_copy [clut_len];
    logic [15:0] lfsr = 16'd3;
    int          cycles = 0;

    `include "tb_gfx_model.svh"

    gfx_top i_dut (
        .clk_sys, .rst_sys, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .rgb, .de, .frame
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;  // 8 ns
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Done: errors found");
            $fatal(1, "timeout, run did not end within %0d cycles", limit);
        end
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        colr_t       v;
        int          n;
        int          len;
        int          p;
        rst_sys <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        repeat (10) @(posedge clk_sys);
        rst_sys <= 1'b0;
        // palette, one LFSR step per bit
        for (int i = 0; i < clut_len; i++) begin
            for (int b = 0; b < colrw; b++) begin
                v    = {v[colrw-2:0], lfsr[0]};
                lfsr = lfsr_step(lfsr);
            end
            clut_copy[i] = v;
            apb_write(reg_clut_base + 8'(4 * i), 32'(v), 1'b0);
        end
        apb_write(8'h20, 32'h5, 1'b1);  // unmapped
        apb_read(reg_clut_base + 8'h04, rdata, err);
        check_value("pslverr", 32'(err), 32'h1);  // CLUT read refused
        for (int i = 0; i < n_lines; i++) begin
            for (int r = 0; r < 5; r++) begin
                apb_write(reg_x0 + 8'(4 * r), 32'(line_tbl[i][r]), 1'b0);
            end
            for (int r = 0; r < 5; r++) begin
                apb_read(reg_x0 + 8'(4 * r), rdata, err);
                check_value({"prdata ", reg_names[r]}, rdata, 32'(line_tbl[i][r]));
                check_value("pslverr", 32'(err), 32'h0);
            end
            apb_write(reg_ctrl, 32'h1, 1'b0);
            draw_ref(line_tbl[i][0], line_tbl[i][1], line_tbl[i][2], line_tbl[i][3],
                     line_tbl[i][4], n);
            if (n >= 20) begin
                apb_read(reg_status, rdata, err);
                check_value("status", rdata, 32'h1);
                apb_write(reg_cidx, 32'(line_tbl[i][4] ^ 15), 1'b0);  // other colour
                apb_write(reg_ctrl, 32'h1, 1'b1);  // dropped, drawer still busy
            end
            rdata = 32'h1;
            while (rdata[0]) begin
                apb_read(reg_status, rdata, err);
            end
        end
        // first frame may have read part of the buffer before the last write
        repeat (2) begin
            @(negedge clk_sys);
            while (!frame) begin
                @(negedge clk_sys);
            end
        end
        len = 0;
        p   = 0;
        do begin
            // raster position follows from the cycles since frame
            check_value("de", 32'(de), 32'((len % h_total < fb_w) && (len / h_total < fb_h)));
            if (de) begin
                check_value("rgb", 32'(rgb), 32'(clut_copy[shadow[p % fb_pixels]]));
                p++;
            end else begin
                check_value("rgb", 32'(rgb), 32'h0);  // blanking is black
            end
            len++;
            @(negedge clk_sys);
        end while (!frame);
        check_value("frame period", len, frame_len);
        check_value("de count", p, fb_pixels);
        $display("Done: no errors");
        $finish;
    end

endmodule
